// ==== common/uart_pkg.sv ====
// UART shared definitions
package uart_pkg;

	////////////////////
	// Bit timing
	////////////////////

	// Clock cycles per serial bit, kept small for simulation
	localparam int CLKS_PER_BIT = 8;
	// Bit-period counter width
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	// Last count of a bit period
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CLKS_PER_BIT - 1);
	// Count at which the start bit is checked, about half a bit in
	localparam logic [BIT_CNT_W-1:0] BIT_MID = BIT_CNT_W'((CLKS_PER_BIT - 1) / 2);

	////////////////////
	// Frame format
	////////////////////

	// Data bits per frame, sent LSB first
	localparam int DATA_BITS = 8;
	// Data bit index width
	localparam int BIT_IDX_W = $clog2(DATA_BITS);

	////////////////////
	// Receive buffer
	////////////////////

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// One received character with its framing status
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic frame_err;
	} rx_char_t;

endpackage

// ==== uart/uart_rx.sv ====
// UART serial receiver
module uart_rx import uart_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_serial,
	output logic     o_wr,
	output rx_char_t o_char
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP,
		S_WRITE
	} rx_state_t;

	rx_state_t state;
	// Two-flop synchronizer on the serial line
	logic sync_meta;
	logic rx_s;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	// Set on the last cycle of a bit period
	logic bit_end;
	rx_char_t char_q;

	////////////////////
	// Synchronizer
	////////////////////

	// Idle level is high, so reset to 1 to avoid a false start
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_meta <= 1'b1;
			rx_s      <= 1'b1;
		end else begin
			sync_meta <= i_serial;
			rx_s      <= sync_meta;
		end
	end

	assign bit_end = (clk_cnt == BIT_LAST);

	////////////////////
	// Frame FSM
	////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= S_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// Falling edge seen on the synced line
					if (!rx_s)
						state <= S_START;
				end
				S_START: begin
					if (clk_cnt == BIT_MID) begin
						// From here every sample lands mid-bit
						clk_cnt <= '0;
						// Still low, so a real start bit. Otherwise a glitch
						state   <= rx_s ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
							state <= S_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						state   <= S_WRITE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				// One cycle to hand the character to the buffer
				S_WRITE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////
	// Character capture
	////////////////////

	always_ff @(posedge i_clk) begin
		// LSB arrives first, shift right
		if (state == S_DATA && bit_end)
			char_q.data <= {rx_s, char_q.data[DATA_BITS-1:1]};
		// Low stop bit flags a framing error
		if (state == S_STOP && bit_end)
			char_q.frame_err <= ~rx_s;
	end

	assign o_wr   = (state == S_WRITE);
	assign o_char = char_q;

endmodule

// ==== uart/uart_tx.sv ====
// UART serial transmitter
module uart_tx import uart_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_valid,
	input  logic [DATA_BITS-1:0] i_data,
	output logic                 o_ready,
	output logic                 o_serial
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP,
		S_DONE
	} tx_state_t;

	tx_state_t state;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic [DATA_BITS-1:0] tx_byte;
	logic accept;
	logic bit_end;

	// Only take a byte while idle
	assign o_ready = (state == S_IDLE);
	assign accept  = i_valid & o_ready;
	assign bit_end = (clk_cnt == BIT_LAST);

	// Byte held for the whole frame
	always_ff @(posedge i_clk) begin
		if (accept)
			tx_byte <= i_data;
	end

	////////////////////
	// Frame sequencer
	////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= S_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			o_serial <= 1'b1;
		end else begin
			case (state)
				S_IDLE: begin
					clk_cnt  <= '0;
					bit_idx  <= '0;
					o_serial <= 1'b1;
					// Start bit goes out right after the accept
					if (accept) begin
						state    <= S_START;
						o_serial <= 1'b0;
					end
				end
				S_START: begin
					if (bit_end) begin
						clk_cnt  <= '0;
						state    <= S_DATA;
						// First data bit of a frame
						o_serial <= tx_byte[0];
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
							state    <= S_STOP;
							o_serial <= 1'b1;
						end else begin
							bit_idx  <= bit_idx + 1'b1;
							o_serial <= tx_byte[bit_idx + 1'b1];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						state   <= S_DONE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				// Line stays high, ready comes back next cycle
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/rx_fifo.sv ====
// Receive character buffer
module rx_fifo import uart_pkg::*; (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_wr,
	input  rx_char_t i_char,
	output logic     o_valid,
	output rx_char_t o_char,
	input  logic     i_ready,
	output logic     o_overrun
);

	rx_char_t mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// One extra bit so full and empty differ
	logic [FIFO_AW:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign pop  = o_valid & i_ready;
	// A pop frees the slot the write needs
	assign push = i_wr & (~full | pop);

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge i_clk) begin
		if (push)
			mem[wr_ptr] <= i_char;
	end

	// Pointers and occupancy
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			o_overrun <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Dropped character, sticky until reset
			if (i_wr & ~push)
				o_overrun <= 1'b1;
		end
	end

	// Oldest entry shown at the output
	assign o_valid = (count != '0);
	assign o_char  = mem[rd_ptr];

endmodule

// ==== hdl/uart_top.sv ====
// UART subsystem top level
module uart_top import uart_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_rx_serial,
	output logic                 o_tx_serial,
	output logic                 o_rx_valid,
	output rx_char_t             o_rx_char,
	input  logic                 i_rx_ready,
	input  logic                 i_tx_valid,
	input  logic [DATA_BITS-1:0] i_tx_data,
	output logic                 o_tx_ready,
	output logic                 o_rx_overrun
);

	// Receiver to buffer, no back-pressure
	logic     rx_wr;
	rx_char_t rx_char;

	uart_rx rx_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_serial (i_rx_serial),
		.o_wr     (rx_wr),
		.o_char   (rx_char)
	);

	rx_fifo fifo_i (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr      (rx_wr),
		.i_char    (rx_char),
		.o_valid   (o_rx_valid),
		.o_char    (o_rx_char),
		.i_ready   (i_rx_ready),
		.o_overrun (o_rx_overrun)
	);

	uart_tx tx_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_valid  (i_tx_valid),
		.i_data   (i_tx_data),
		.o_ready  (o_tx_ready),
		.o_serial (o_tx_serial)
	);

endmodule

// ==== verif/uart_sva.sv ====
// UART handshake assertions
module uart_sva import uart_pkg::*; (
	input logic     i_clk,
	input logic     i_rst_n,
	input logic     i_tx_valid,
	input logic     i_tx_ready,
	input logic     i_tx_line,
	input logic     i_buf_valid,
	input rx_char_t i_buf_char,
	input logic     i_buf_ready
);

	logic tx_accept;

	assign tx_accept = i_tx_valid & i_tx_ready;

	// Line idles high whenever a byte can be taken
	tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_tx_ready |-> i_tx_line) else $error("tx line low while ready");

	// Ready comes back only at the end of a full frame
	tx_ready_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(i_tx_ready) |-> $past(tx_accept, 10 * CLKS_PER_BIT + 2))
		else $error("tx ready rose before frame end");

	tx_ready_back: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$past(tx_accept, 10 * CLKS_PER_BIT + 2) |-> i_tx_ready)
		else $error("tx ready missing at frame end");

	// Held output stays put until popped
	buf_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_buf_valid && !i_buf_ready |=> i_buf_valid && $stable(i_buf_char))
		else $error("buffer output changed while stalled");

endmodule

bind uart_tx uart_sva tx_sva_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_tx_valid  (i_valid),
	.i_tx_ready  (o_ready),
	.i_tx_line   (o_serial),
	.i_buf_valid (1'b0),
	.i_buf_char  ('0),
	.i_buf_ready (1'b1)
);

bind rx_fifo uart_sva fifo_sva_i (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_tx_valid  (1'b0),
	.i_tx_ready  (1'b0),
	.i_tx_line   (1'b1),
	.i_buf_valid (o_valid),
	.i_buf_char  (o_char),
	.i_buf_ready (i_ready)
);

// ==== verif/uart_tb.sv ====
// UART subsystem testbench
module uart_tb import uart_pkg::*;;

	// Things the testbench can wait on
	typedef enum {
		WAIT_RX_VALID,
		WAIT_TX_READY,
		WAIT_OVERRUN
	} wait_sel_t;

	logic                 clk;
	logic                 rst_n;
	// Serial line into the DUT, driven or looped back
	logic                 rx_drive;
	logic                 loopback;
	logic                 rx_line;
	logic                 tx_line;
	logic                 rx_valid;
	rx_char_t             rx_char;
	logic                 rx_ready;
	logic                 tx_valid;
	logic [DATA_BITS-1:0] tx_data;
	logic                 tx_ready;
	logic                 rx_overrun;
	logic [15:0]          lfsr_state;
	int                   cycle_cnt;

	assign rx_line = loopback ? tx_line : rx_drive;

	uart_top dut_i (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_rx_serial  (rx_line),
		.o_tx_serial  (tx_line),
		.o_rx_valid   (rx_valid),
		.o_rx_char    (rx_char),
		.i_rx_ready   (rx_ready),
		.i_tx_valid   (tx_valid),
		.i_tx_data    (tx_data),
		.o_tx_ready   (tx_ready),
		.o_rx_overrun (rx_overrun)
	);

	////////////////////
	// Clock and timeout
	////////////////////

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 30 frames of 10 bits, plus half again
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == 30 * 10 * CLKS_PER_BIT * 3 / 2) begin
			$display("Run exceeded %0d clock cycles without finishing", cycle_cnt);
			$display("ERRORS FOUND");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
				$time, msg, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		else
			return state >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_byte(output logic [7:0] b);
		repeat (8) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {lfsr_state[0], b[7:1]};
		end
	endtask

	function automatic logic is_high(input wait_sel_t sel);
		case (sel)
			WAIT_RX_VALID: return rx_valid;
			WAIT_TX_READY: return tx_ready;
			default:       return rx_overrun;
		endcase
	endfunction

	// Polls on falling edges, bounded to about a frame and a half
	task automatic wait_for(input wait_sel_t sel, input string what);
		int n;
		n = 0;
		while (is_high(sel) !== 1'b1) begin
			if (n > 12 * CLKS_PER_BIT) begin
				$display("Timed out waiting for %s", what);
				$display("ERRORS FOUND");
				$fatal(1, "handshake wait expired");
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	// Start, 8 data bits LSB first, chosen stop level, one idle bit
	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		logic [7:0] shift;
		shift = data;
		rx_drive = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		repeat (DATA_BITS) begin
			rx_drive = shift[0];
			shift = shift >> 1;
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		rx_drive = stop_level;
		repeat (CLKS_PER_BIT) @(negedge clk);
		rx_drive = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	// Returns on the falling edge right after the accept
	task automatic send_tx_byte(input logic [7:0] b);
		wait_for(WAIT_TX_READY, "transmitter ready");
		tx_valid = 1'b1;
		tx_data  = b;
		@(posedge clk);
		@(negedge clk);
		tx_valid = 1'b0;
	endtask

	task automatic pop_char(input logic [7:0] exp_data, input logic exp_err,
			input string what);
		wait_for(WAIT_RX_VALID, what);
		check(32'(rx_char.data), 32'(exp_data), {what, " data"});
		check(32'(rx_char.frame_err), 32'(exp_err), {what, " frame_err"});
		rx_ready = 1'b1;
		@(negedge clk);
		rx_ready = 1'b0;
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset();
		check(32'(tx_line), 32'd1, "reset tx line");
		check(32'(tx_ready), 32'd1, "reset tx ready");
		check(32'(rx_valid), 32'd0, "reset rx valid");
		check(32'(rx_overrun), 32'd0, "reset overrun");
	endtask

	task automatic test_tx_frame(input logic [7:0] b);
		logic [9:0] frame;
		int elapsed;
		int k;
		// Stop, data, start from MSB down
		frame = {1'b1, b, 1'b0};
		send_tx_byte(b);
		elapsed = 0;
		for (k = 0; k < 10; k++) begin
			// Mid-bit of bit k, counted from the accept edge
			repeat (k * CLKS_PER_BIT + CLKS_PER_BIT / 2 - elapsed) @(posedge clk);
			elapsed = k * CLKS_PER_BIT + CLKS_PER_BIT / 2;
			@(negedge clk);
			check(32'(tx_line), 32'(frame[0]), $sformatf("tx frame bit %0d", k));
			frame = frame >> 1;
		end
		while (tx_ready !== 1'b1 && elapsed < 12 * CLKS_PER_BIT) begin
			@(posedge clk);
			elapsed++;
			@(negedge clk);
		end
		check(32'(elapsed), 32'(10 * CLKS_PER_BIT + 1), "tx ready return cycle");
	endtask

	task automatic test_rx_frame();
		logic [7:0] b;
		random_byte(b);
		send_frame(b, 1'b1);
		pop_char(b, 1'b0, "rx good frame");
		check(32'(rx_valid), 32'd0, "rx buffer empty after pop");
		// Start pulse under half a bit
		rx_drive = 1'b0;
		repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
		rx_drive = 1'b1;
		repeat (12 * CLKS_PER_BIT) @(negedge clk);
		check(32'(rx_valid), 32'd0, "short start pulse ignored");
	endtask

	task automatic test_frame_error();
		logic [7:0] b;
		random_byte(b);
		send_frame(b, 1'b0);
		pop_char(b, 1'b1, "rx low stop bit");
		check(32'(rx_valid), 32'd0, "no extra char after low stop");
	endtask

	task automatic test_overrun();
		logic [7:0] sent [$];
		logic [7:0] b;
		int i;
		check(32'(rx_overrun), 32'd0, "overrun clear before fill");
		check(32'(rx_valid), 32'd0, "buffer empty before fill");
		for (i = 0; i < FIFO_DEPTH + 1; i++) begin
			random_byte(b);
			sent.push_back(b);
			send_frame(b, 1'b1);
		end
		wait_for(WAIT_OVERRUN, "overrun flag");
		for (i = 0; i < FIFO_DEPTH; i++) begin
			b = sent.pop_front();
			pop_char(b, 1'b0, $sformatf("buffered char %0d", i));
		end
		check(32'(rx_valid), 32'd0, "dropped char absent");
		check(32'(rx_overrun), 32'd1, "overrun still set");
	endtask

	task automatic test_loopback();
		logic [7:0] b;
		int i;
		loopback = 1'b1;
		for (i = 0; i < 16; i++) begin
			random_byte(b);
			send_tx_byte(b);
			pop_char(b, 1'b0, $sformatf("loopback char %0d", i));
		end
		loopback = 1'b0;
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		rst_n      = 1'b0;
		rx_drive   = 1'b1;
		loopback   = 1'b0;
		rx_ready   = 1'b0;
		tx_valid   = 1'b0;
		tx_data    = '0;
		cycle_cnt  = 0;
		lfsr_state = 16'd46135;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_reset();
		test_tx_frame(8'hA5);
		test_rx_frame();
		test_frame_error();
		test_overrun();
		test_loopback();
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== sources.f ====
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/rx_fifo.sv
hdl/uart_top.sv
verif/uart_sva.sv
verif/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the UART testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module uart_tb -f sources.f -o uart_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
sim_failed=""
./obj_dir/uart_sim > sim.log 2>&1 || sim_failed=1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation FAILED"; exit 1; }
[ -z "$sim_failed" ] || { echo "Simulation exited with an error status"; exit 1; }
echo "Simulation PASSED"
exit 0
